/* design/asym_pkg.sv */
package asym_pkg;

   // port widths on the two sides of the converter
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // one ram lane per narrow item in a wide word
   localparam int LANES      = W_DATA_W / R_DATA_W;
   localparam int LANE_SEL_W = $clog2(LANES);

   // 16 words, addressed by word on the write side and by byte on the read side
   localparam int WORD_ADDR_W = 4;
   localparam int BYTE_ADDR_W = WORD_ADDR_W + LANE_SEL_W;

   // ping-pong halves
   localparam int HALF_WORDS = 8;
   localparam int HALF_BYTES = HALF_WORDS * LANES;

   typedef struct packed {
      logic                   en;
      logic [WORD_ADDR_W-1:0] addr;
      logic [W_DATA_W-1:0]    data;
   } wr_req_t;

   typedef struct packed {
      logic                   en;
      logic [BYTE_ADDR_W-1:0] addr;
   } rd_req_t;

   typedef struct packed {
      logic [LANES-1:0]       en;
      logic [WORD_ADDR_W-1:0] addr;
      logic [W_DATA_W-1:0]    data;
   } lane_wr_t;

   typedef struct packed {
      logic [LANES-1:0]       en;
      logic [WORD_ADDR_W-1:0] addr;
   } lane_rd_t;

endpackage

/* design/frame_writer.sv */
module frame_writer
   import asym_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                in_valid_i,
   input  logic [W_DATA_W-1:0] in_data_i,
   input  logic                half_release_i,
   input  logic                release_half_i,
   output wr_req_t             wr_o,
   output logic                half_ready_o,
   output logic                ready_half_o,
   output logic                overflow_o
);

   logic [WORD_ADDR_W-1:0] wr_ptr;
   logic [1:0]             busy;
   logic                   tgt_half;
   logic                   accept;
   logic                   half_full;
   logic                   half_ready_q;
   logic                   ready_half_q;
   logic                   overflow_q;

   // msb of the word pointer picks the half
   assign tgt_half  = wr_ptr[WORD_ADDR_W-1];
   assign accept    = in_valid_i && !busy[tgt_half];
   // last word slot of the current half
   assign half_full = &wr_ptr[$clog2(HALF_WORDS)-1:0];

   // word goes straight into the ram at this edge
   assign wr_o.en   = accept;
   assign wr_o.addr = wr_ptr;
   assign wr_o.data = in_data_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr       <= '0;
         busy         <= '0;
         half_ready_q <= 1'b0;
         overflow_q   <= 1'b0;
      end else begin
         half_ready_q <= 1'b0;
         if (half_release_i) begin
            busy[release_half_i] <= 1'b0;
         end
         if (accept) begin
            wr_ptr <= wr_ptr + 1'b1;
            if (half_full) begin
               half_ready_q   <= 1'b1;
               busy[tgt_half] <= 1'b1;
            end
         end
         // word aimed at a half still being drained
         if (in_valid_i && busy[tgt_half]) begin
            overflow_q <= 1'b1;
         end
      end
   end

   // id travels with the pulse
   always_ff @(posedge clk_i) begin
      if (accept && half_full) begin
         ready_half_q <= tgt_half;
      end
   end

   assign half_ready_o = half_ready_q;
   assign ready_half_o = ready_half_q;
   assign overflow_o   = overflow_q;

   // a half is only handed over if it was free while it filled
   a_ready_free : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      half_ready_o |-> $past(!busy[tgt_half]));

endmodule

/* design/asym_width_converter.sv */
module asym_width_converter
   import asym_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  wr_req_t             wr_i,
   input  rd_req_t             rd_i,
   output lane_wr_t            lane_wr_o,
   output lane_rd_t            lane_rd_o,
   input  logic [W_DATA_W-1:0] lane_rdata_i,
   output logic [R_DATA_W-1:0] rdata_o
);

   logic [LANE_SEL_W-1:0] lane_sel_q;
   logic [W_DATA_W-1:0]   shifted;

   // wide write hits all lanes at once
   assign lane_wr_o.en   = {LANES{wr_i.en}};
   assign lane_wr_o.addr = wr_i.addr;
   assign lane_wr_o.data = wr_i.data;

   // narrow read enables a single lane, low bits pick it
   assign lane_rd_o.en   = {{(LANES - 1) {1'b0}}, rd_i.en} << rd_i.addr[LANE_SEL_W-1:0];
   assign lane_rd_o.addr = rd_i.addr[BYTE_ADDR_W-1:LANE_SEL_W];

   // lane select lines up with the registered ram output
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         lane_sel_q <= '0;
      end else begin
         lane_sel_q <= rd_i.addr[LANE_SEL_W-1:0];
      end
   end

   assign shifted = lane_rdata_i >> (lane_sel_q * R_DATA_W);
   assign rdata_o = shifted[R_DATA_W-1:0];

   // a read never hits the word being written in the same cycle
   a_lane_wr_en : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(wr_i.en && rd_i.en && lane_rd_o.addr == wr_i.addr));

endmodule

/* design/lane_ram.sv */
module lane_ram
   import asym_pkg::*;
(
   input  logic                clk_i,
   input  lane_wr_t            lane_wr_i,
   input  lane_rd_t            lane_rd_i,
   output logic [W_DATA_W-1:0] rdata_o
);

   genvar l;

   generate
      for (l = 0; l < LANES; l++) begin : g_lane
         logic [R_DATA_W-1:0] mem [2**WORD_ADDR_W];
         logic [R_DATA_W-1:0] rdata_q;

         // byte slice l of the wide word
         always_ff @(posedge clk_i) begin
            if (lane_wr_i.en[l]) begin
               mem[lane_wr_i.addr] <= lane_wr_i.data[l*R_DATA_W +: R_DATA_W];
            end
         end

         // output holds while this lane is not read
         always_ff @(posedge clk_i) begin
            if (lane_rd_i.en[l]) begin
               rdata_q <= mem[lane_rd_i.addr];
            end
         end

         assign rdata_o[l*R_DATA_W +: R_DATA_W] = rdata_q;
      end
   endgenerate

   // narrow side reads one lane at a time
   a_one_lane_rd : assert property (@(posedge clk_i)
      $onehot0(lane_rd_i.en));

endmodule

/* design/byte_reader.sv */
module byte_reader
   import asym_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                half_ready_i,
   input  logic                ready_half_i,
   input  logic [R_DATA_W-1:0] rdata_i,
   output rd_req_t             rd_o,
   output logic                half_release_o,
   output logic                release_half_o,
   output logic                out_valid_o,
   output logic [R_DATA_W-1:0] out_data_o
);

   logic [1:0]                    pending;
   logic                          cur_half;
   logic [$clog2(HALF_BYTES)-1:0] byte_cnt;
   logic                          rd_en;
   logic                          last_rd;
   logic                          rd_q;
   logic                          last_q;
   logic                          last_half_q;

   // halves come strictly in turn, so only the current one matters
   assign rd_en   = pending[cur_half];
   assign last_rd = rd_en && (&byte_cnt);

   assign rd_o.en   = rd_en;
   assign rd_o.addr = {cur_half, byte_cnt};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pending  <= '0;
         cur_half <= 1'b0;
         byte_cnt <= '0;
      end else begin
         if (half_ready_i) begin
            pending[ready_half_i] <= 1'b1;
         end
         if (rd_en) begin
            byte_cnt <= byte_cnt + 1'b1;
         end
         // counter wraps to 0, next half may start right away
         if (last_rd) begin
            pending[cur_half] <= 1'b0;
            cur_half          <= ~cur_half;
         end
      end
   end

   // strobes delayed to meet the byte coming back
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_q   <= 1'b0;
         last_q <= 1'b0;
      end else begin
         rd_q   <= rd_en;
         last_q <= last_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (last_rd) begin
         last_half_q <= cur_half;
      end
   end

   assign out_valid_o    = rd_q;
   assign out_data_o     = rdata_i;
   assign half_release_o = last_q;
   assign release_half_o = last_half_q;

   // once started, a half is read without gaps
   a_no_gap : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (byte_cnt != '0) |-> rd_o.en && $past(rd_o.en));

endmodule

/* design/asym_stream_top.sv */
module asym_stream_top
   import asym_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                in_valid_i,
   input  logic [W_DATA_W-1:0] in_data_i,
   output logic                out_valid_o,
   output logic [R_DATA_W-1:0] out_data_o,
   output logic                overflow_o
);

   wr_req_t             wr_req;
   rd_req_t             rd_req;
   lane_wr_t            lane_wr;
   lane_rd_t            lane_rd;
   logic [W_DATA_W-1:0] lane_rdata;
   logic [R_DATA_W-1:0] rd_byte;
   logic                half_ready;
   logic                ready_half;
   logic                half_release;
   logic                release_half;

   frame_writer u_writer (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .in_valid_i    (in_valid_i),
      .in_data_i     (in_data_i),
      .half_release_i(half_release),
      .release_half_i(release_half),
      .wr_o          (wr_req),
      .half_ready_o  (half_ready),
      .ready_half_o  (ready_half),
      .overflow_o    (overflow_o)
   );

   asym_width_converter u_conv (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wr_i        (wr_req),
      .rd_i        (rd_req),
      .lane_wr_o   (lane_wr),
      .lane_rd_o   (lane_rd),
      .lane_rdata_i(lane_rdata),
      .rdata_o     (rd_byte)
   );

   lane_ram u_ram (
      .clk_i    (clk_i),
      .lane_wr_i(lane_wr),
      .lane_rd_i(lane_rd),
      .rdata_o  (lane_rdata)
   );

   byte_reader u_reader (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .half_ready_i  (half_ready),
      .ready_half_i  (ready_half),
      .rdata_i       (rd_byte),
      .rd_o          (rd_req),
      .half_release_o(half_release),
      .release_half_o(release_half),
      .out_valid_o   (out_valid_o),
      .out_data_o    (out_data_o)
   );

endmodule

/* verif/asym_stream_tb.sv */
module asym_stream_tb
   import asym_pkg::*;
;

   logic                clk;
   logic                rst_n;
   logic                in_valid;
   logic [W_DATA_W-1:0] in_data;
   logic                out_valid;
   logic [R_DATA_W-1:0] out_data;
   logic                overflow;

   // reference model state
   logic [R_DATA_W-1:0]    exp_q[$];
   logic [R_DATA_W-1:0]    exp_b;
   logic [WORD_ADDR_W-1:0] m_ptr;
   logic [1:0]             m_busy;
   logic                   m_out_half;
   int                     m_out_cnt;
   logic                   m_overflow;

   logic [31:0] rng;
   string       test_name;
   int          errors;
   int          bytes_seen;
   int          accepted;

   asym_stream_top asym_stream_top_i (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .in_valid_i (in_valid),
      .in_data_i  (in_data),
      .out_valid_o(out_valid),
      .out_data_o (out_data),
      .overflow_o (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // model and monitor, evaluated where inputs and outputs are stable
   always @(negedge clk) begin
      if (!rst_n) begin
         exp_q.delete();
         m_ptr      = '0;
         m_busy     = '0;
         m_out_half = 1'b0;
         m_out_cnt  = 0;
         m_overflow = 1'b0;
      end else begin
         // a word aimed at a half still owned by the reader is lost
         if (in_valid) begin
            if (m_busy[m_ptr[WORD_ADDR_W-1]]) begin
               m_overflow = 1'b1;
            end else begin
               for (int k = 0; k < LANES; k++) begin
                  exp_q.push_back(in_data[k*R_DATA_W +: R_DATA_W]);
               end
               accepted++;
               if ((m_ptr % HALF_WORDS) == HALF_WORDS - 1) begin
                  m_busy[m_ptr[WORD_ADDR_W-1]] = 1'b1;
               end
               m_ptr = m_ptr + 1'b1;
            end
         end
         if (out_valid === 1'b1) begin
            bytes_seen++;
            if (exp_q.size() == 0) begin
               $display("%s: byte %02h came out with nothing expected", test_name, out_data);
               errors++;
            end else begin
               exp_b = exp_q.pop_front();
               if (out_data !== exp_b) begin
                  $display("FAIL %s: expected %02h, actual %02h", test_name, exp_b, out_data);
                  errors++;
               end
            end
            // 32nd byte frees the half at the next edge
            m_out_cnt++;
            if (m_out_cnt == HALF_BYTES) begin
               m_busy[m_out_half] = 1'b0;
               m_out_half         = ~m_out_half;
               m_out_cnt          = 0;
            end
         end
      end
   end

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         #1;
         if (i == 2) begin
            rst_n = 1'b1;
         end
         @(negedge clk);
         if (out_valid !== 1'b0 || overflow !== 1'b0) begin
            $display("%s: out_valid or overflow not low around reset", test_name);
            errors++;
         end
      end
   endtask

   task automatic send_words(input int n, input int spacing);
      for (int i = 0; i < n; i++) begin
         @(posedge clk);
         #1;
         in_valid = 1'b1;
         in_data  = rng;
         rng      = xorshift(rng);
         repeat (spacing - 1) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
         end
      end
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic wait_drain(input int max_cycles);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < max_cycles) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("%s: timed out with %0d bytes never output", test_name, exp_q.size());
         errors++;
      end
   endtask

   // no stray bytes once the stream is idle
   task automatic idle_check(input int cycles);
      int b0;
      b0 = bytes_seen;
      repeat (cycles) @(posedge clk);
      if (bytes_seen != b0) begin
         $display("FAIL %s: expected 0 extra bytes, actual %0d", test_name, bytes_seen - b0);
         errors++;
      end
   endtask

   task automatic check_bytes(input int b0, input int expected);
      if (bytes_seen - b0 != expected) begin
         $display("FAIL %s: expected %0d bytes, actual %0d", test_name, expected,
                  bytes_seen - b0);
         errors++;
      end
   endtask

   task automatic check_overflow(input logic expected);
      if (overflow !== expected || m_overflow !== expected) begin
         $display("FAIL %s: expected overflow %0b, actual %0b", test_name, expected, overflow);
         errors++;
      end
   endtask

   task automatic test_reset_state();
      test_name = "reset_state";
      apply_reset();
      idle_check(20);
      check_overflow(1'b0);
   endtask

   task automatic test_single_half();
      int b0;
      test_name = "single_half";
      b0 = bytes_seen;
      send_words(8, 1);
      wait_drain(200);
      idle_check(40);
      check_bytes(b0, 32);
      check_overflow(1'b0);
   endtask

   task automatic test_streaming();
      int b0;
      test_name = "streaming";
      b0 = bytes_seen;
      send_words(40, 4);
      wait_drain(300);
      idle_check(40);
      check_bytes(b0, 160);
      check_overflow(1'b0);
   endtask

   task automatic test_overflow();
      int b0;
      int a0;
      test_name = "overflow";
      b0 = bytes_seen;
      a0 = accepted;
      send_words(24, 1);
      if (accepted - a0 != 16) begin
         $display("FAIL %s: expected 16 words kept, actual %0d", test_name, accepted - a0);
         errors++;
      end
      check_overflow(1'b1);
      wait_drain(400);
      idle_check(20);
      check_bytes(b0, 64);
      // recovery once the reader has released both halves
      b0 = bytes_seen;
      send_words(8, 1);
      wait_drain(200);
      idle_check(20);
      check_bytes(b0, 32);
      check_overflow(1'b1);
   endtask

   task automatic test_reset_clears_overflow();
      int b0;
      test_name = "reset_clears_overflow";
      apply_reset();
      check_overflow(1'b0);
      b0 = bytes_seen;
      send_words(8, 1);
      wait_drain(200);
      idle_check(20);
      check_bytes(b0, 32);
      check_overflow(1'b0);
   endtask

   initial begin
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      rng        = 32'hf57e7560;
      errors     = 0;
      bytes_seen = 0;
      accepted   = 0;
      test_name  = "init";
      test_reset_state();
      test_single_half();
      test_streaming();
      test_overflow();
      test_reset_clears_overflow();
      $display("summary: %0d errors, %0d bytes checked", errors, bytes_seen);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
design/asym_pkg.sv
design/frame_writer.sv
design/asym_width_converter.sv
design/lane_ram.sv
design/byte_reader.sv
design/asym_stream_top.sv
verif/asym_stream_tb.sv
